/* design/neuro_pkg.sv */
package neuro_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    // tick half count, same span as the board delay counter
    localparam int HALF_CNT_W = 18;
    // one spike count per window
    localparam int CNT_W      = 16;
    // signed emg envelope
    localparam int EMG_W      = 18;
    // headroom for old emg, leak and count * gain
    localparam int EMG_SUM_W  = 36;

    // emg saturation limits
    localparam int EMG_MAX = (1 << (EMG_W - 1)) - 1;
    localparam int EMG_MIN = -(1 << (EMG_W - 1));

    ////////////////////////////////////////////////////////////////////////////
    // parameter reset values
    ////////////////////////////////////////////////////////////////////////////

    localparam int HALF_CNT_RST = 4;
    localparam int WINDOW_RST   = 8;
    localparam int GAIN_RST     = 1;
    localparam int SHIFT_RST    = 2;

    // simulation state
    typedef enum logic [1:0] {
        SIM_IDLE = 2'd0,
        SIM_RUN  = 2'd1,
        SIM_DUMP = 2'd2
    } sim_state_e;

    // host load addresses, anything else is ignored
    typedef enum logic [3:0] {
        PA_HALF_CNT     = 4'd0,
        PA_WINDOW       = 4'd1,
        PA_GAIN         = 4'd2,
        PA_SHIFT        = 4'd3,
        PA_HALF_CNT_EXT = 4'd4
    } param_addr_e;

endpackage

/* design/neuro_ctrl_if.sv */
`timescale 1ns/1ps

interface neuro_ctrl_if;

    // level, high while simulating (run and dump states)
    logic run;
    // one cycle per simulation tick
    logic tick;
    // tick that closes a window
    logic window_done;
    // one cycle, counters latch and emg steps
    logic dump;

    // tick divider side
    modport timer (
        input  run,
        output tick,
        output window_done
    );

    // state machine side
    modport fsm (
        input  window_done,
        output run,
        output dump
    );

    // counters and emg filter
    modport data (
        input  run,
        input  dump
    );

endinterface

/* design/param_bank.sv */
`timescale 1ns/1ps

module param_bank
    import neuro_pkg::*;
(
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  i_load,
    input  param_addr_e           i_load_addr,
    input  logic [15:0]           i_wire_lo,
    input  logic [15:0]           i_wire_hi,
    output logic [HALF_CNT_W-1:0] o_half_cnt,
    output logic [CNT_W-1:0]      o_window_len,
    output logic [CNT_W-1:0]      o_gain,
    output logic [3:0]            o_shift
);

    // held parameter values
    logic [HALF_CNT_W-1:0] half_cnt_q;
    logic [CNT_W-1:0]      window_len_q;
    logic [CNT_W-1:0]      gain_q;
    logic [3:0]            shift_q;

    ////////////////////////////////////////////////////////////////////////////
    // decoded write, one address per load strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            half_cnt_q   <= HALF_CNT_W'(HALF_CNT_RST);
            window_len_q <= CNT_W'(WINDOW_RST);
            gain_q       <= CNT_W'(GAIN_RST);
            shift_q      <= 4'(SHIFT_RST);
        end
        else if (i_load)
        begin
            case (i_load_addr)
                // low 16 bits of the half count
                PA_HALF_CNT:     half_cnt_q[15:0] <= i_wire_lo;
                PA_WINDOW:       window_len_q <= i_wire_lo;
                PA_GAIN:         gain_q <= i_wire_lo;
                PA_SHIFT:        shift_q <= i_wire_lo[3:0];
                // top 2 bits of the half count
                PA_HALF_CNT_EXT: half_cnt_q[HALF_CNT_W-1:16] <= i_wire_lo[1:0];
                default:         ;
            endcase
        end
    end

    // hi wire carries no field at these addresses

    assign o_half_cnt   = half_cnt_q;
    assign o_window_len = window_len_q;
    assign o_gain       = gain_q;
    assign o_shift      = shift_q;

endmodule

/* design/tick_timer.sv */
`timescale 1ns/1ps

module tick_timer
    import neuro_pkg::*;
(
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic [HALF_CNT_W-1:0] i_half_cnt,
    input  logic [CNT_W-1:0]      i_window_len,
    neuro_ctrl_if.timer           ctl
);

    // clamped settings, zero behaves as one
    logic [HALF_CNT_W-1:0] half_c;
    logic [CNT_W-1:0]      win_c;

    logic [HALF_CNT_W-1:0] cyc_q;
    logic [CNT_W-1:0]      tick_cnt_q;
    // idle slot after a window, lines up with the dump cycle
    logic                  hold_q;
    logic                  tick_w;
    logic                  done_w;

    assign half_c = (i_half_cnt == '0) ? HALF_CNT_W'(1) : i_half_cnt;
    assign win_c  = (i_window_len == '0) ? CNT_W'(1) : i_window_len;

    // >= keeps things sane if the host shrinks a setting mid-window
    assign tick_w = ctl.run && !hold_q && (cyc_q >= half_c);
    assign done_w = tick_w && (tick_cnt_q >= win_c - CNT_W'(1));

    assign ctl.tick        = tick_w;
    assign ctl.window_done = done_w;

    ////////////////////////////////////////////////////////////////////////////
    // cycle and tick counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || !ctl.run)
        begin
            // stopped, start fresh on next run
            cyc_q      <= '0;
            tick_cnt_q <= '0;
            hold_q     <= 1'b0;
        end
        else if (hold_q)
        begin
            hold_q <= 1'b0;
        end
        else if (tick_w)
        begin
            cyc_q <= '0;
            if (done_w)
            begin
                tick_cnt_q <= '0;
                hold_q     <= 1'b1;
            end
            else
                tick_cnt_q <= tick_cnt_q + CNT_W'(1);
        end
        else
            cyc_q <= cyc_q + HALF_CNT_W'(1);
    end

endmodule

/* design/sim_fsm.sv */
`timescale 1ns/1ps

module sim_fsm
    import neuro_pkg::*;
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        i_start,
    input  logic        i_stop,
    neuro_ctrl_if.fsm   ctl,
    output sim_state_e  o_state
);

    sim_state_e state_q;
    sim_state_e state_d;

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            SIM_IDLE:
            begin
                // start only counts from idle
                if (i_start)
                    state_d = SIM_RUN;
            end
            SIM_RUN:
            begin
                if (ctl.window_done)
                    state_d = SIM_DUMP;
            end
            // single dump cycle, back to running
            SIM_DUMP: state_d = SIM_RUN;
            default:  state_d = SIM_IDLE;
        endcase
        // stop wins from any state
        if (i_stop)
            state_d = SIM_IDLE;
    end

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            state_q <= SIM_IDLE;
        else
            state_q <= state_d;
    end

    // decoded controls
    assign ctl.run  = (state_q != SIM_IDLE);
    assign ctl.dump = (state_q == SIM_DUMP);
    assign o_state  = state_q;

endmodule

/* design/spike_counter.sv */
`timescale 1ns/1ps

module spike_counter
    import neuro_pkg::*;
(
    input  logic             ep50trig,
    input  logic             reset_global,
    input  logic             i_spike,
    neuro_ctrl_if.data       ctl,
    output logic [CNT_W-1:0] o_count
);

    // running total for the open window
    logic [CNT_W-1:0] acc_q;
    logic [CNT_W-1:0] acc_d;
    // last completed window
    logic [CNT_W-1:0] count_q;

    // saturating add, only while running
    assign acc_d = (ctl.run && i_spike && (acc_q != '1)) ? acc_q + CNT_W'(1) : acc_q;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            acc_q   <= '0;
            count_q <= '0;
        end
        else if (!ctl.run)
            // partial window dropped on stop
            acc_q <= '0;
        else if (ctl.dump)
        begin
            // total includes the dump cycle itself
            count_q <= acc_d;
            acc_q   <= '0;
        end
        else
            acc_q <= acc_d;
    end

    assign o_count = count_q;

endmodule

/* design/emg_filter.sv */
`timescale 1ns/1ps

module emg_filter
    import neuro_pkg::*;
(
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic [CNT_W-1:0]        i_count,
    input  logic [CNT_W-1:0]        i_gain,
    input  logic [3:0]              i_shift,
    neuro_ctrl_if.data              ctl,
    output logic signed [EMG_W-1:0] o_emg
);

    logic signed [EMG_W-1:0]     emg_q;
    // count is latched on the dump edge, so step on the cycle after
    logic                        step_q;
    logic signed [EMG_W-1:0]     leak;
    // full width count * gain
    logic [2*CNT_W-1:0]          prod;
    logic signed [EMG_SUM_W-1:0] drive;
    logic signed [EMG_SUM_W-1:0] sum;
    logic signed [EMG_W-1:0]     emg_d;

    // emg - emg >>> shift + count * gain
    assign leak  = emg_q >>> i_shift;
    assign prod  = i_count * i_gain;
    assign drive = $signed(EMG_SUM_W'(prod));
    assign sum   = EMG_SUM_W'(emg_q) - EMG_SUM_W'(leak) + drive;

    // clip to signed 18 bit
    always_comb
    begin
        if (sum > EMG_MAX)
            emg_d = EMG_W'(EMG_MAX);
        else if (sum < EMG_MIN)
            emg_d = EMG_W'(EMG_MIN);
        else
            emg_d = sum[EMG_W-1:0];
    end

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            emg_q  <= '0;
            step_q <= 1'b0;
        end
        else
        begin
            step_q <= ctl.dump;
            if (step_q)
                emg_q <= emg_d;
        end
    end

    // new value shows in the strobe cycle, held after that
    assign o_emg = step_q ? emg_d : emg_q;

endmodule

/* design/neuro_board_top.sv */
`timescale 1ns/1ps

module neuro_board_top
    import neuro_pkg::*;
(
    input  logic                    ep50trig,
    input  logic                    reset_global,
    // host parameter path
    input  logic                    i_load,
    input  param_addr_e             i_load_addr,
    input  logic [15:0]             i_wire_lo,
    input  logic [15:0]             i_wire_hi,
    // run control
    input  logic                    i_start,
    input  logic                    i_stop,
    // short and long latency spike trains
    input  logic                    i_spike_sl,
    input  logic                    i_spike_ll,
    output sim_state_e              o_state,
    output logic [CNT_W-1:0]        o_cnt_sl,
    output logic [CNT_W-1:0]        o_cnt_ll,
    output logic [CNT_W-1:0]        o_cnt_comb,
    output logic signed [EMG_W-1:0] o_emg,
    output logic                    o_window_valid
);

    logic [HALF_CNT_W-1:0] half_cnt;
    logic [CNT_W-1:0]      window_len;
    logic [CNT_W-1:0]      gain;
    logic [3:0]            shift;
    // OR of both loops
    logic                  spike_comb;
    logic                  valid_q;

    neuro_ctrl_if ctl ();

    param_bank u_params (
        .ep50trig, .reset_global, .i_load, .i_load_addr, .i_wire_lo, .i_wire_hi,
        .o_half_cnt(half_cnt), .o_window_len(window_len), .o_gain(gain), .o_shift(shift)
    );

    tick_timer u_timer (
        .ep50trig, .reset_global, .i_half_cnt(half_cnt), .i_window_len(window_len),
        .ctl(ctl.timer)
    );

    sim_fsm u_fsm (
        .ep50trig, .reset_global, .i_start, .i_stop, .ctl(ctl.fsm), .o_state
    );

    ////////////////////////////////////////////////////////////////////////////
    // spike counters, one per train
    ////////////////////////////////////////////////////////////////////////////

    assign spike_comb = i_spike_sl | i_spike_ll;

    spike_counter u_cnt_sl (
        .ep50trig, .reset_global, .i_spike(i_spike_sl), .ctl(ctl.data), .o_count(o_cnt_sl)
    );

    spike_counter u_cnt_ll (
        .ep50trig, .reset_global, .i_spike(i_spike_ll), .ctl(ctl.data), .o_count(o_cnt_ll)
    );

    spike_counter u_cnt_comb (
        .ep50trig, .reset_global, .i_spike(spike_comb), .ctl(ctl.data), .o_count(o_cnt_comb)
    );

    // envelope from the combined count
    emg_filter u_emg (
        .ep50trig, .reset_global, .i_count(o_cnt_comb), .i_gain(gain), .i_shift(shift),
        .ctl(ctl.data), .o_emg
    );

    // strobe lines up with the freshly latched counts
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            valid_q <= 1'b0;
        else
            valid_q <= ctl.dump;
    end

    assign o_window_valid = valid_q;

endmodule

/* dv/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one row per test
// name, half count, window length, gain, shift, spike density out of 256,
// windows to collect, run cycles before a mid-window stop (0 means no stop)
typedef struct {
    string name;
    int    half_cnt;
    int    window_len;
    int    gain;
    int    shift;
    int    density;
    int    windows;
    int    stop_at;
} vec_t;

localparam int NUM_VECS = 7;

vec_t vec_tab [NUM_VECS] = '{
    '{"base",         4,  8, 1,          2,  64, 4,  0},
    // half count of 0 runs as 1
    '{"half_zero",    0,  5, 3,          1, 128, 4,  0},
    '{"long_tick",    9,  3, 2,          3,  96, 3,  0},
    '{"dense",        2, 12, 5,          4, 200, 5,  0},
    // big gain drives the envelope into the positive limit
    '{"emg_sat",      1, 16, 16'hffff,   6, 220, 4,  0},
    '{"stop_restart", 3,  6, 2,          2, 128, 3, 40},
    // window length of 0 runs as 1
    '{"window_zero",  2,  0, 1,          0, 100, 6,  0}
};

`endif

/* dv/tb_neuro_board.sv */
`timescale 1ns/1ps

module tb_neuro_board
    import neuro_pkg::*;
();

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 8;
    localparam int ROW_MARGIN     = 64;
    localparam int TIMEOUT_MARGIN = 256;

    logic                    ep50trig = 1'b0;
    logic                    reset_global;
    logic                    i_load;
    param_addr_e             i_load_addr;
    logic [15:0]             i_wire_lo;
    logic [15:0]             i_wire_hi;
    logic                    i_start;
    logic                    i_stop;
    logic                    i_spike_sl;
    logic                    i_spike_ll;
    sim_state_e              o_state;
    logic [CNT_W-1:0]        o_cnt_sl;
    logic [CNT_W-1:0]        o_cnt_ll;
    logic [CNT_W-1:0]        o_cnt_comb;
    logic signed [EMG_W-1:0] o_emg;
    logic                    o_window_valid;

    `include "tb_vectors.svh"

    integer seed;
    int     errors;
    int     checks;
    int     cycles;
    int     cycle_limit;
    int     valid_total;
    string  cur_name;

    // reference model, stepped on the falling edge
    sim_state_e              m_state;
    logic                    m_valid;
    int                      m_idx;
    int                      m_period;
    int                      m_gain;
    int                      m_shift;
    int                      acc_sl;
    int                      acc_ll;
    int                      acc_comb;
    logic [CNT_W-1:0]        e_sl;
    logic [CNT_W-1:0]        e_ll;
    logic [CNT_W-1:0]        e_comb;
    logic signed [EMG_W-1:0] m_emg;

    neuro_board_top UUT (.*);

    always #(CLK_PERIOD / 2) ep50trig = ~ep50trig;

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_state(input string what, input sim_state_e exp, input sim_state_e act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Error %s: expected %s actual %s", what, exp.name(), act.name());
        end
    endtask

    task automatic check_count(input string what, input logic [CNT_W-1:0] exp,
                               input logic [CNT_W-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Error %s: expected %0d actual %0d", what, exp, act);
        end
    endtask

    task automatic check_emg(input string what, input logic signed [EMG_W-1:0] exp,
                             input logic signed [EMG_W-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Error %s: expected %0d actual %0d", what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Error %s: expected %0b actual %0b", what, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int nonzero(input int v);
        return (v == 0) ? 1 : v;
    endfunction

    // old - old >>> shift + count * gain, clipped to signed 18 bit
    function automatic logic signed [EMG_W-1:0] emg_recursion(input logic signed [EMG_W-1:0] old,
                                                              input int cnt, input int gain,
                                                              input int shift);
        longint s;
        s = longint'(old) - (longint'(old) >>> shift) + longint'(cnt) * longint'(gain);
        if (s > EMG_MAX)
            s = EMG_MAX;
        else if (s < EMG_MIN)
            s = EMG_MIN;
        return EMG_W'(s);
    endfunction

    task automatic model_reset();
        m_state  = SIM_IDLE;
        m_valid  = 1'b0;
        m_idx    = 0;
        acc_sl   = 0;
        acc_ll   = 0;
        acc_comb = 0;
        e_sl     = '0;
        e_ll     = '0;
        e_comb   = '0;
        m_emg    = '0;
    endtask

    // inputs seen here are the ones the DUT takes on the next rising edge
    task automatic model_cycle();
        m_valid = (m_state == SIM_DUMP);
        if (m_state != SIM_IDLE)
        begin
            acc_sl   += i_spike_sl;
            acc_ll   += i_spike_ll;
            acc_comb += (i_spike_sl | i_spike_ll);
        end
        // dump cycle closes the window, its own spikes included
        if (m_state == SIM_DUMP)
        begin
            e_sl     = CNT_W'(acc_sl);
            e_ll     = CNT_W'(acc_ll);
            e_comb   = CNT_W'(acc_comb);
            m_emg    = emg_recursion(m_emg, acc_comb, m_gain, m_shift);
            acc_sl   = 0;
            acc_ll   = 0;
            acc_comb = 0;
        end
        if (i_stop)
        begin
            m_state  = SIM_IDLE;
            acc_sl   = 0;
            acc_ll   = 0;
            acc_comb = 0;
        end
        else if (m_state == SIM_IDLE)
        begin
            if (i_start)
            begin
                m_state = SIM_RUN;
                m_idx   = 0;
            end
        end
        else
        begin
            // last cycle of every period is the dump
            m_idx++;
            m_state = (m_idx % m_period == m_period - 1) ? SIM_DUMP : SIM_RUN;
        end
    endtask

    task automatic window_seen();
        valid_total++;
        checks++;
        if (o_cnt_comb < ((o_cnt_sl > o_cnt_ll) ? o_cnt_sl : o_cnt_ll) ||
            o_cnt_comb > {1'b0, o_cnt_sl} + o_cnt_ll)
        begin
            errors++;
            $display("%s: combined count %0d lies outside the range set by %0d and %0d",
                     cur_name, o_cnt_comb, o_cnt_sl, o_cnt_ll);
        end
    endtask

    always @(negedge ep50trig)
    begin
        if (reset_global)
            model_reset();
        else
        begin
            check_state({cur_name, " state"}, m_state, o_state);
            check_flag({cur_name, " window_valid"}, m_valid, o_window_valid);
            check_count({cur_name, " cnt_sl"}, e_sl, o_cnt_sl);
            check_count({cur_name, " cnt_ll"}, e_ll, o_cnt_ll);
            check_count({cur_name, " cnt_comb"}, e_comb, o_cnt_comb);
            check_emg({cur_name, " emg"}, m_emg, o_emg);
            if (o_window_valid)
                window_seen();
            model_cycle();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_param(input param_addr_e addr, input logic [15:0] data);
        @(posedge ep50trig);
        i_load      <= 1'b1;
        i_load_addr <= addr;
        i_wire_lo   <= data;
        // hi wire is unused, keep it busy
        i_wire_hi   <= ~data;
    endtask

    task automatic drive_spikes(input int density, input logic en);
        logic [31:0] r;
        r = $random(seed);
        i_spike_sl <= en && (r[7:0] < density);
        i_spike_ll <= en && (r[15:8] < density);
    endtask

    task automatic start_run();
        @(posedge ep50trig);
        i_load     <= 1'b0;
        i_start    <= 1'b1;
        i_spike_sl <= 1'b0;
        i_spike_ll <= 1'b0;
        @(posedge ep50trig);
        i_start    <= 1'b0;
    endtask

    task automatic stop_run();
        @(posedge ep50trig);
        i_stop     <= 1'b1;
        i_spike_sl <= 1'b0;
        i_spike_ll <= 1'b0;
        @(posedge ep50trig);
        i_stop     <= 1'b0;
    endtask

    task automatic run_row(input int idx);
        vec_t v;
        int   err0;
        int   base;
        v        = vec_tab[idx];
        err0     = errors;
        cur_name = v.name;
        m_gain   = v.gain;
        m_shift  = v.shift;
        m_period = (nonzero(v.half_cnt) + 1) * nonzero(v.window_len) + 1;
        load_param(PA_HALF_CNT, 16'(v.half_cnt));
        load_param(PA_HALF_CNT_EXT, 16'(v.half_cnt >> 16));
        load_param(PA_WINDOW, 16'(v.window_len));
        load_param(PA_GAIN, 16'(v.gain));
        load_param(PA_SHIFT, 16'(v.shift));
        start_run();
        if (v.stop_at != 0)
        begin
            repeat (v.stop_at)
            begin
                @(posedge ep50trig);
                drive_spikes(v.density, 1'b1);
            end
            stop_run();
            // spikes while idle must not count
            repeat (3)
            begin
                @(posedge ep50trig);
                drive_spikes(v.density, 1'b1);
            end
            start_run();
        end
        base = valid_total;
        while (valid_total - base < v.windows)
        begin
            @(posedge ep50trig);
            // last window stays quiet so nothing is lost at the stop
            drive_spikes(v.density, (valid_total - base) < (v.windows - 1));
        end
        stop_run();
        repeat (2) @(posedge ep50trig);
        $display("test %s finished with %0d windows and %0d errors",
                 v.name, valid_total - base, errors - err0);
    endtask

    // sum of (half + 1) * window * (windows + 2) over the rows
    function automatic int timeout_limit();
        int total;
        int i;
        total = TIMEOUT_MARGIN;
        for (i = 0; i < NUM_VECS; i++)
            total += (nonzero(vec_tab[i].half_cnt) + 1) * nonzero(vec_tab[i].window_len)
                     * (vec_tab[i].windows + 2) + ROW_MARGIN;
        return total;
    endfunction

    always @(posedge ep50trig)
    begin
        if (!reset_global)
        begin
            cycles++;
            if (cycles > cycle_limit)
            begin
                $display("timeout after %0d cycles while running %s", cycles, cur_name);
                $display("Result: FAILED");
                $finish;
            end
        end
    end

    initial
    begin
        seed         = 32'h149ff6cb;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        valid_total  = 0;
        m_period     = 3;
        m_gain       = GAIN_RST;
        m_shift      = SHIFT_RST;
        cur_name     = "reset";
        cycle_limit  = timeout_limit();
        reset_global = 1'b1;
        i_load       = 1'b0;
        i_load_addr  = PA_HALF_CNT;
        i_wire_lo    = '0;
        i_wire_hi    = '0;
        i_start      = 1'b0;
        i_stop       = 1'b0;
        i_spike_sl   = 1'b0;
        i_spike_ll   = 1'b0;
        repeat (RESET_CYCLES) @(posedge ep50trig);
        reset_global <= 1'b0;
        // idle after reset, spikes ignored without start
        repeat (4)
        begin
            @(posedge ep50trig);
            drive_spikes(128, 1'b1);
        end
        for (int i = 0; i < NUM_VECS; i++)
            run_row(i);
        $display("%0d tests, %0d checks, %0d errors", NUM_VECS, checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* files.f */
+incdir+dv
design/neuro_pkg.sv
design/neuro_ctrl_if.sv
design/param_bank.sv
design/tick_timer.sv
design/sim_fsm.sv
design/spike_counter.sv
design/emg_filter.sv
design/neuro_board_top.sv
dv/tb_neuro_board.sv
